//--- source/tetris_pkg.sv
package tetris_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Board geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int board_rows = 20;
    localparam int board_cols = 10;

    // Row 0 is the top row. Bit c of a row is column c.
    typedef logic [board_rows-1:0][board_cols-1:0] board_t;
    typedef logic [4:0] row_idx_t;
    typedef logic [3:0] col_idx_t;

    localparam logic [7:0] score_max = 8'd255; // Score saturates here.

    // Codes 2 to 4 are reserved.
    typedef enum logic [2:0] {
        st_idle   = 3'd0,
        st_place  = 3'd1,
        st_landed = 3'd5,
        st_eval   = 3'd6,
        st_commit = 3'd7
    } game_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pieces
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        piece_i = 3'd0,
        piece_o = 3'd1,
        piece_t = 3'd2,
        piece_s = 3'd3,
        piece_z = 3'd4,
        piece_j = 3'd5,
        piece_l = 3'd6
    } piece_kind_t;

    typedef logic [1:0] rotation_t; // Quarter turns clockwise.

    localparam int shape_size = 4;

    // Row-major 4x4 box with bit 15 as the top-left cell.
    typedef logic [shape_size*shape_size-1:0] shape_t;

    // Indexed by kind * 4 + rotation.
    localparam shape_t shape_table [28] = '{
        16'h0F00, 16'h2222, 16'h00F0, 16'h4444, // I.
        16'hCC00, 16'hCC00, 16'hCC00, 16'hCC00, // O.
        16'h4E00, 16'h4640, 16'h0E40, 16'h4C40, // T.
        16'h6C00, 16'h4620, 16'h06C0, 16'h8C40, // S.
        16'hC600, 16'h2640, 16'h0C60, 16'h4C80, // Z.
        16'h8E00, 16'h6440, 16'h0E20, 16'h44C0, // J.
        16'h2E00, 16'h4460, 16'h0E80, 16'hC440  // L.
    };

endpackage

//--- source/board_if.sv
interface board_if
    import tetris_pkg::*;
(
    input game_state_t state
);

    board_t stored_array;  // Board as held by the merge stage.
    board_t cleared_array; // Board after row removal.
    logic   eval_complete;

    // Board storage side.
    modport storage (
        output stored_array,
        input  cleared_array,
        input  state
    );

    // Row clearing side.
    modport clear (
        output cleared_array,
        output eval_complete,
        input  stored_array,
        input  state
    );

endinterface

//--- source/piece_rasterizer.sv
module piece_rasterizer
    import tetris_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        lock,
    input  piece_kind_t kind,
    input  rotation_t   rotation,
    input  row_idx_t    lock_row,
    input  col_idx_t    lock_col,
    input  game_state_t state,
    output logic        mask_valid,
    output board_t      mask
);

    shape_t shape;
    board_t next_mask;
    logic   take_lock;

    assign take_lock = lock && (state == st_idle); // Locks while busy are dropped.
    assign shape     = shape_table[{kind, rotation}];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Place the 4x4 box at (lock_row, lock_col)
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Walking board cells means anything off the board simply never lands.
    always_comb begin
        next_mask = '0;
        for (int r = 0; r < board_rows; r++) begin
            for (int c = 0; c < board_cols; c++) begin
                int dr;
                int dc;
                dr = r - int'(lock_row);
                dc = c - int'(lock_col);
                if (dr >= 0 && dr < shape_size && dc >= 0 && dc < shape_size) begin
                    next_mask[r][c] =
                        shape[(shape_size - 1 - dr) * shape_size + (shape_size - 1 - dc)];
                end
            end
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            mask_valid <= 1'b0;
        end else begin
            mask_valid <= take_lock; // One-cycle strobe.
        end
    end

    always_ff @(posedge clk) begin
        if (take_lock) begin
            mask <= next_mask;
        end
    end

endmodule

//--- source/board_merge.sv
module board_merge
    import tetris_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   mask_valid,
    input  board_t mask,
    board_if.storage bif,
    output logic   overlap,
    output board_t board
);

    board_t hits;
    logic   collided;

    // Cells the new piece shares with the settled board.
    assign hits     = board & mask;
    assign collided = |hits;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Board storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            board   <= '0;
            overlap <= 1'b0;
        end else if (mask_valid) begin
            board   <= board | mask; // Merged even on a collision.
            overlap <= collided;
        end else if (bif.state == st_commit) begin
            board <= bif.cleared_array;
        end
    end

    // The clear stage loads from here during st_landed.
    assign bif.stored_array = board;

endmodule

//--- source/line_clear.sv
module line_clear
    import tetris_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    board_if.clear     bif,
    output logic [7:0] score
);

    row_idx_t   eval_row;
    row_idx_t   next_eval_row;
    logic       eval_done;
    logic       next_eval_done;
    board_t     work;
    board_t     next_work;
    logic [7:0] next_score;
    logic       row_full;

    assign row_full = &work[eval_row];

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            eval_row  <= row_idx_t'(board_rows - 1);
            eval_done <= 1'b0;
            work      <= '0;
            score     <= 8'd0;
        end else begin
            eval_row  <= next_eval_row;
            eval_done <= next_eval_done;
            work      <= next_work;
            score     <= next_score;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bottom-up row scan
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        next_eval_row  = eval_row;
        next_eval_done = eval_done;
        next_work      = work;
        next_score     = score;

        if (bif.state == st_landed) begin
            next_eval_row  = row_idx_t'(board_rows - 1); // Start at the bottom.
            next_eval_done = 1'b0;
            next_work      = bif.stored_array;
        end else if (bif.state == st_eval && !eval_done) begin
            if (row_full) begin
                // Drop everything above the full row by one.
                for (int k = board_rows - 1; k > 0; k--) begin
                    if (k <= int'(eval_row)) begin
                        next_work[k] = work[k-1];
                    end
                end
                next_work[0] = '0;
                if (score != score_max) begin
                    next_score = score + 8'd1;
                end
                // Same row again. It now holds what was above.
            end else if (eval_row == '0) begin
                next_eval_done = 1'b1;
            end else begin
                next_eval_row = eval_row - row_idx_t'(1);
            end
        end
    end

    assign bif.cleared_array = work;
    assign bif.eval_complete = eval_done;

endmodule

//--- source/game_sequencer.sv
module game_sequencer
    import tetris_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        lock,
    input  logic        eval_complete,
    output game_state_t state,
    output logic        busy,
    output logic        done
);

    game_state_t next_state;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= st_idle;
            done  <= 1'b0;
        end else begin
            state <= next_state;
            done  <= (state == st_commit); // Lands with the return to idle.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next-state logic
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (lock) begin
                    next_state = st_place;
                end
            end
            st_place: begin
                next_state = st_landed;
            end
            st_landed: begin
                next_state = st_eval;
            end
            st_eval: begin
                if (eval_complete) begin
                    next_state = st_commit;
                end
            end
            st_commit: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle; // Reserved codes.
            end
        endcase
    end

    assign busy = (state != st_idle);

endmodule

//--- source/playfield_top.sv
module playfield_top
    import tetris_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        lock,
    input  piece_kind_t kind,
    input  rotation_t   rotation,
    input  row_idx_t    lock_row,
    input  col_idx_t    lock_col,
    output logic        busy,
    output logic        done,
    output logic        overlap,
    output logic [7:0]  score,
    output board_t      board
);

    game_state_t state;
    logic        mask_valid;
    board_t      mask;

    board_if u_bif (
        .state (state)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    game_sequencer u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .lock          (lock),
        .eval_complete (u_bif.eval_complete),
        .state         (state),
        .busy          (busy),
        .done          (done)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath stages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    piece_rasterizer u_rasterizer (
        .clk        (clk),
        .reset      (reset),
        .lock       (lock),
        .kind       (kind),
        .rotation   (rotation),
        .lock_row   (lock_row),
        .lock_col   (lock_col),
        .state      (state),
        .mask_valid (mask_valid),
        .mask       (mask)
    );

    board_merge u_merge (
        .clk        (clk),
        .reset      (reset),
        .mask_valid (mask_valid),
        .mask       (mask),
        .bif        (u_bif.storage),
        .overlap    (overlap),
        .board      (board)
    );

    line_clear u_clear (
        .clk   (clk),
        .reset (reset),
        .bif   (u_bif.clear),
        .score (score)
    );

endmodule

//--- verification/playfield_model.svh
`ifndef playfield_model_svh
`define playfield_model_svh

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the playfield
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Box cell (br, bc) lands on board cell (row + br, col + bc).
function automatic board_t model_mask(input piece_kind_t k, input rotation_t rot,
                                      input int row, input int col);
    board_t m;
    shape_t s;
    m = '0;
    s = shape_table[int'(k) * 4 + int'(rot)];
    for (int br = 0; br < 4; br++) begin
        for (int bc = 0; bc < 4; bc++) begin
            if (s[4'(15 - br * 4 - bc)] && (row + br) < board_rows && (col + bc) < board_cols) begin
                m[row_idx_t'(row + br)][col_idx_t'(col + bc)] = 1'b1;
            end
        end
    end
    return m;
endfunction

function automatic void model_merge(input board_t old_board, input board_t piece_mask,
                                    output board_t merged, output logic hit);
    merged = old_board | piece_mask;
    hit    = |(old_board & piece_mask); // Any shared cell.
endfunction

// Keeps the rows that are not full and stacks them from the bottom.
function automatic void model_clear(input board_t b, output board_t cleared,
                                    output int rows_removed);
    int dst;
    cleared      = '0;
    rows_removed = 0;
    dst          = board_rows - 1;
    for (int r = board_rows - 1; r >= 0; r--) begin
        if (&b[row_idx_t'(r)]) begin
            rows_removed++;
        end else begin
            cleared[row_idx_t'(dst)] = b[row_idx_t'(r)];
            dst--;
        end
    end
endfunction

function automatic logic [7:0] model_score(input logic [7:0] old_score, input int rows);
    int sum;
    sum = int'(old_score) + rows;
    if (sum > int'(score_max)) begin
        return score_max; // Saturated.
    end
    return 8'(sum);
endfunction

`endif

//--- verification/playfield_tb.sv
module playfield_tb
    import tetris_pkg::*;
();

    logic        clk;
    logic        reset;
    logic        lock;
    piece_kind_t kind;
    rotation_t   rotation;
    row_idx_t    lock_row;
    col_idx_t    lock_col;
    logic        busy;
    logic        done;
    logic        overlap;
    logic [7:0]  score;
    board_t      board;

    board_t      exp_board;
    logic [7:0]  exp_score;
    logic        exp_overlap;
    int          seed;
    int          checks;
    int          errors;
    int          errors_at_start;
    int          total_cleared;
    int          locks;

    `include "playfield_model.svh"

    playfield_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .lock     (lock),
        .kind     (kind),
        .rotation (rotation),
        .lock_row (lock_row),
        .lock_col (lock_col),
        .busy     (busy),
        .done     (done),
        .overlap  (overlap),
        .score    (score),
        .board    (board)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare on every done pulse
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (done && !reset) begin
            checks += 3;
            assert (board == exp_board) else begin
                $display("error: board expected %h actual %h", exp_board, board);
                errors++;
            end
            assert (score == exp_score) else begin
                $display("error: score expected %h actual %h", exp_score, score);
                errors++;
            end
            assert (overlap == exp_overlap) else begin
                $display("error: overlap expected %h actual %h", exp_overlap, overlap);
                errors++;
            end
        end
    end

    function automatic int pick_below(input int n);
        return ($random(seed) & 32'h7fffffff) % n;
    endfunction

    task automatic require_low(input string name, input logic value);
        checks++;
        assert (value == 1'b0) else begin
            $display("error: %s expected 0 actual %h", name, value);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset         = 1'b0;
        exp_board     = '0;
        exp_score     = 8'd0;
        exp_overlap   = 1'b0;
        total_cleared = 0;
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        require_low("busy", busy);
        require_low("done", done);
        require_low("overlap", overlap);
        checks += 2;
        assert (score == 8'd0) else begin
            $display("error: score expected %h actual %h", 8'd0, score);
            errors++;
        end
        assert (board == '0) else begin
            $display("error: board expected %h actual %h", board_t'(0), board);
            errors++;
        end
    endtask

    // Updates the model, then pulses lock for one cycle.
    task automatic start_lock(input piece_kind_t k, input rotation_t r,
                              input int row, input int col);
        board_t m;
        board_t merged;
        board_t cleared;
        logic   hit;
        int     n;
        @(posedge clk);
        #1;
        m = model_mask(k, r, row, col);
        model_merge(exp_board, m, merged, hit);
        model_clear(merged, cleared, n);
        exp_board     = cleared;
        exp_overlap   = hit;
        exp_score     = model_score(exp_score, n);
        total_cleared += n;
        kind     = k;
        rotation = r;
        lock_row = row_idx_t'(row);
        lock_col = col_idx_t'(col);
        lock     = 1'b1;
        @(posedge clk);
        #1;
        lock = 1'b0;
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("done never arrived within 200 cycles of the lock");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            #1; // Compare process runs first.
        end
    endtask

    // A second lock while the first one is still in flight.
    task automatic lock_while_busy();
        @(posedge clk);
        #1;
        checks++;
        assert (busy) else begin
            $display("error: busy expected 1 actual %h", busy);
            errors++;
        end
        kind     = piece_i;
        rotation = 2'd0;
        lock_row = 5'd0;
        lock_col = 4'd0;
        lock     = 1'b1;
        @(posedge clk);
        #1;
        lock = 1'b0;
    endtask

    task automatic watch_idle();
        repeat (5) begin
            @(negedge clk);
            require_low("busy", busy);
            require_low("done", done);
        end
    endtask

    task automatic report_test(input string name);
        int n;
        n = errors - errors_at_start;
        if (n == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, n);
        end
        errors_at_start = errors;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        seed            = 32'h20190164;
        reset           = 1'b1;
        lock            = 1'b0;
        kind            = piece_i;
        rotation        = 2'd0;
        lock_row        = 5'd0;
        lock_col        = 4'd0;
        exp_board       = '0;
        exp_score       = 8'd0;
        exp_overlap     = 1'b0;
        checks          = 0;
        errors          = 0;
        errors_at_start = 0;
        total_cleared   = 0;

        apply_reset();
        check_reset_state();
        report_test("reset");

        // Each shape goes once anywhere and once against the bottom-right edge.
        for (int k = 0; k < 7; k++) begin
            for (int r = 0; r < 4; r++) begin
                apply_reset();
                start_lock(piece_kind_t'(k), rotation_t'(r), pick_below(20), pick_below(10));
                wait_for_done();
                start_lock(piece_kind_t'(k), rotation_t'(r), 17 + pick_below(3),
                           7 + pick_below(3));
                wait_for_done();
            end
        end
        report_test("placements");

        apply_reset();
        start_lock(piece_i, 2'd0, 18, 0);
        wait_for_done();
        start_lock(piece_i, 2'd0, 18, 4);
        wait_for_done();
        start_lock(piece_i, 2'd1, 16, 6); // Column 8 leaves nine cells in row 19.
        wait_for_done();
        start_lock(piece_i, 2'd1, 16, 7);
        wait_for_done();
        checks++;
        assert (score == 8'd1) else begin
            $display("error: score expected %h actual %h", 8'd1, score);
            errors++;
        end
        report_test("single_clear");

        apply_reset();
        start_lock(piece_i, 2'd0, 18, 0);
        wait_for_done();
        start_lock(piece_i, 2'd0, 18, 4);
        wait_for_done();
        start_lock(piece_i, 2'd0, 17, 0);
        wait_for_done();
        start_lock(piece_i, 2'd0, 17, 4);
        wait_for_done();
        start_lock(piece_o, 2'd0, 18, 8); // Rows 18 and 19 at once.
        wait_for_done();
        start_lock(piece_i, 2'd0, 18, 0);
        wait_for_done();
        start_lock(piece_i, 2'd0, 18, 4);
        wait_for_done();
        start_lock(piece_i, 2'd0, 16, 0);
        wait_for_done();
        start_lock(piece_i, 2'd0, 16, 4);
        wait_for_done();
        start_lock(piece_i, 2'd1, 16, 6);
        wait_for_done();
        start_lock(piece_i, 2'd1, 16, 7); // Clears rows 17 and 19 and keeps row 18.
        wait_for_done();
        report_test("multi_clear");

        apply_reset();
        start_lock(piece_o, 2'd0, 10, 3);
        wait_for_done();
        start_lock(piece_t, 2'd0, 10, 3);
        lock_while_busy();
        wait_for_done();
        watch_idle();
        start_lock(piece_i, 2'd0, 0, 0);
        wait_for_done();
        report_test("overlap_busy");

        apply_reset();
        locks = 0;
        while (total_cleared <= 255 && locks < 6000) begin
            start_lock(piece_kind_t'(pick_below(7)), rotation_t'(pick_below(4)),
                       12 + pick_below(8), pick_below(10));
            wait_for_done();
            locks++;
        end
        checks++;
        assert (total_cleared > 255) else begin
            $display("score never passed 255 within %0d locks", locks);
            errors++;
        end
        report_test("saturation");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+verification
source/tetris_pkg.sv
source/board_if.sv
source/piece_rasterizer.sv
source/board_merge.sv
source/line_clear.sv
source/game_sequencer.sv
source/playfield_top.sv
verification/playfield_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the playfield testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module playfield_tb -o playfield_sim

./obj_dir/playfield_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0
